/* rtl/csrMerge.sv */
// CSR mask merge and change flags
module csrMerge
    import rvfiPkg::*;
    import rvviPkg::*;
(
    input  logic                   rvvi,
    input  logic                   rst_i,
    input  logic                   capture_i,
    input  csrRec_t [CSR_COUNT-1:0] csrIn_i,
    output xWord_t  [CSR_COUNT-1:0] csrVal_o,
    output csrMask_t               csrWb_o
);

    xWord_t [CSR_COUNT-1:0] merged;
    csrMask_t               changed;

    ////////////////////
    // Per CSR merge
    ////////////////////
    for (genvar c = 0; c < CSR_COUNT; c++) begin : gCsr
        // Written bits from wdata, the rest from rdata
        assign merged[c] = (csrIn_i[c].wdata & csrIn_i[c].wmask)
                         | (csrIn_i[c].rdata & ~csrIn_i[c].wmask);
        // Against the last reported value
        assign changed[c] = (merged[c] != csrVal_o[c]);
    end

    ////////////////////
    // Value and flag registers
    ////////////////////
    // Value register doubles as the shadow of what was last sent
    always_ff @(posedge rvvi) begin
        if (rst_i) begin
            csrVal_o <= '0;
            csrWb_o  <= '0;
        end else if (capture_i) begin
            csrVal_o <= merged;
            csrWb_o  <= changed;
        end
    end

endmodule

/* rtl/netMonitor.sv */
// Net change detection and event latch
module netMonitor
    import rvviPkg::*;
(
    input  logic                 rvvi,
    input  logic                 rst_i,
    input  logic [NET_COUNT-1:0] nets_i,
    input  logic                 netLoad_i,
    output logic                 netPending_o,
    output netEvent_t            netEvent_o
);

    // Level last sent per net
    logic [NET_COUNT-1:0] lastReported;
    logic [NET_COUNT-1:0] pendVec;
    netIdx_t              selIdx;

    ////////////////////
    // Pending and select
    ////////////////////
    // A line back at its reported level drops out on its own
    assign pendVec      = nets_i ^ lastReported;
    assign netPending_o = |pendVec;

    // Lowest pending index
    always_comb begin
        selIdx = '0;
        for (int n = NET_COUNT - 1; n >= 0; n--) begin
            if (pendVec[n])
                selIdx = netIdx_t'(n);
        end
    end

    ////////////////////
    // Registers
    ////////////////////
    always_ff @(posedge rvvi) begin
        if (rst_i)
            lastReported <= '0;
        else if (netLoad_i)
            lastReported[selIdx] <= nets_i[selIdx];
    end

    // Event payload, stable until the next load
    always_ff @(posedge rvvi) begin
        if (netLoad_i) begin
            netEvent_o.idx   <= selIdx;
            netEvent_o.value <= nets_i[selIdx];
        end
    end

endmodule

/* rtl/retireCapture.sv */
// Retirement field register and GPR write-back decode
module retireCapture
    import rvfiPkg::*;
    import rvviPkg::*;
(
    input  logic          rvvi,
    input  logic          capture_i,
    input  retireIn_t     retire_i,
    output retireFields_t fields_o
);

    gprMask_t              xWbNext;
    xWord_t [RD_SLOTS-1:0] rdDataNext;

    ////////////////////
    // GPR write-back
    ////////////////////
    always_comb begin
        xWbNext = '0;
        // x0 never reported
        for (int s = 0; s < RD_SLOTS; s++) begin
            if (retire_i.rdAddr[s] != '0)
                xWbNext[retire_i.rdAddr[s]] = 1'b1;
        end
    end

    always_comb begin
        rdDataNext = retire_i.rdWdata;
        // Same register in two slots, last slot wins
        for (int s = 0; s < RD_SLOTS - 1; s++) begin
            if (retire_i.rdAddr[s] == retire_i.rdAddr[RD_SLOTS-1])
                rdDataNext[s] = retire_i.rdWdata[RD_SLOTS-1];
        end
    end

    ////////////////////
    // Field register
    ////////////////////
    // Held until the next acceptance
    always_ff @(posedge rvvi) begin
        if (capture_i) begin
            fields_o.order  <= retire_i.order;
            fields_o.insn   <= retire_i.insn;
            fields_o.pc     <= retire_i.pc;
            fields_o.trap   <= retire_i.trap;
            fields_o.intr   <= retire_i.intr;
            fields_o.mode   <= retire_i.mode;
            fields_o.xWb    <= xWbNext;
            fields_o.rdData <= rdDataNext;
        end
    end

endmodule

/* rtl/rvfiPkg.sv */
// RVFI retirement record types
package rvfiPkg;

    ////////////////////
    // Widths and counts
    ////////////////////
    localparam int XLEN      = 32;
    // Destination register slots per retirement
    localparam int RD_SLOTS  = 2;
    // Tracked machine CSRs, one record each
    localparam int CSR_COUNT = 8;

    typedef logic [XLEN-1:0] xWord_t;
    typedef logic [4:0]      regAddr_t;
    // Retirement sequence number
    typedef logic [63:0]     order_t;
    // Privilege mode, 3 is machine
    typedef logic [1:0]      mode_t;

    ////////////////////
    // Records
    ////////////////////
    // One CSR as seen at retirement
    typedef struct packed {
        xWord_t rdata;
        xWord_t wdata;
        xWord_t wmask;
    } csrRec_t;

    // Full retirement, one per accepted beat
    typedef struct packed {
        order_t                   order;
        xWord_t                   insn;
        xWord_t                   pc;
        logic                     trap;
        logic                     intr;
        mode_t                    mode;
        regAddr_t [RD_SLOTS-1:0]  rdAddr;
        xWord_t   [RD_SLOTS-1:0]  rdWdata;
        csrRec_t  [CSR_COUNT-1:0] csr;
    } retireIn_t;

endpackage

/* rtl/rvviPkg.sv */
// RVVI trace record types and tables
package rvviPkg;
    import rvfiPkg::*;

    ////////////////////
    // CSR side
    ////////////////////
    typedef logic [$clog2(CSR_COUNT)-1:0] csrIdx_t;
    typedef logic [11:0]                  csrAddr_t;
    // One change flag per tracked CSR
    typedef logic [CSR_COUNT-1:0]         csrMask_t;
    // One write-back bit per GPR
    typedef logic [2**$bits(regAddr_t)-1:0] gprMask_t;

    // CSR address by index
    localparam csrAddr_t CSR_ADDR [CSR_COUNT] = '{
        12'h300,  // mstatus
        12'h304,  // mie
        12'h305,  // mtvec
        12'h340,  // mscratch
        12'h341,  // mepc
        12'h342,  // mcause
        12'h344,  // mip
        12'hB02   // minstret
    };

    ////////////////////
    // Nets
    ////////////////////
    // Interrupt nets first, haltreq last
    localparam int NET_IRQ_COUNT = 19;
    localparam int NET_COUNT     = NET_IRQ_COUNT + 1;

    typedef logic [$clog2(NET_COUNT)-1:0] netIdx_t;
    typedef logic [4:0]                   irqLine_t;

    localparam netIdx_t NET_HALTREQ = netIdx_t'(NET_IRQ_COUNT);

    // Core irq line behind each interrupt net
    localparam irqLine_t NET_IRQ_LINE [NET_IRQ_COUNT] = '{
        5'd3,  5'd7,  5'd11,
        5'd16, 5'd17, 5'd18, 5'd19, 5'd20, 5'd21, 5'd22, 5'd23,
        5'd24, 5'd25, 5'd26, 5'd27, 5'd28, 5'd29, 5'd30, 5'd31
    };

    typedef struct packed {
        netIdx_t idx;
        logic    value;
    } netEvent_t;

    ////////////////////
    // Outgoing record
    ////////////////////
    // Everything but the CSRs
    typedef struct packed {
        order_t                 order;
        xWord_t                 insn;
        xWord_t                 pc;
        logic                   trap;
        logic                   intr;
        mode_t                  mode;
        gprMask_t               xWb;
        xWord_t [RD_SLOTS-1:0]  rdData;
    } retireFields_t;

    typedef struct packed {
        retireFields_t          fields;
        xWord_t [CSR_COUNT-1:0] csr;
        csrMask_t               csrWb;
    } traceOut_t;

endpackage

/* rtl/rvviTraceConv.sv */
// RVFI to RVVI trace converter
module rvviTraceConv
    import rvfiPkg::*;
    import rvviPkg::*;
(
    input  logic                 rvvi,
    input  logic                 rst_i,
    // Retirement stream
    input  logic                 retireValid_i,
    input  retireIn_t            retire_i,
    output logic                 retireRdy_o,
    input  logic [NET_COUNT-1:0] nets_i,
    // Record channel
    output logic                 traceReq_o,
    output traceOut_t            trace_o,
    input  logic                 traceAck_i,
    // Net event channel
    output logic                 netReq_o,
    output netEvent_t            netEvent_o,
    input  logic                 netAck_i
);

    logic                   capture;
    logic                   netPending;
    logic                   netLoad;
    retireFields_t          fields;
    xWord_t [CSR_COUNT-1:0] csrVal;
    csrMask_t               csrWb;

    ////////////////////
    // Control
    ////////////////////
    traceCtrl u_traceCtrl (
        .rvvi          (rvvi),
        .rst_i         (rst_i),
        .retireValid_i (retireValid_i),
        .retireRdy_o   (retireRdy_o),
        .capture_o     (capture),
        .netPending_i  (netPending),
        .netLoad_o     (netLoad),
        .netReq_o      (netReq_o),
        .netAck_i      (netAck_i),
        .traceReq_o    (traceReq_o),
        .traceAck_i    (traceAck_i)
    );

    ////////////////////
    // Datapath
    ////////////////////
    retireCapture u_retireCapture (
        .rvvi      (rvvi),
        .capture_i (capture),
        .retire_i  (retire_i),
        .fields_o  (fields)
    );

    csrMerge u_csrMerge (
        .rvvi      (rvvi),
        .rst_i     (rst_i),
        .capture_i (capture),
        .csrIn_i   (retire_i.csr),
        .csrVal_o  (csrVal),
        .csrWb_o   (csrWb)
    );

    netMonitor u_netMonitor (
        .rvvi         (rvvi),
        .rst_i        (rst_i),
        .nets_i       (nets_i),
        .netLoad_i    (netLoad),
        .netPending_o (netPending),
        .netEvent_o   (netEvent_o)
    );

    // Outgoing record
    assign trace_o.fields = fields;
    assign trace_o.csr    = csrVal;
    assign trace_o.csrWb  = csrWb;

endmodule

/* rtl/traceCtrl.sv */
// Trace control FSM
module traceCtrl (
    input  logic rvvi,
    input  logic rst_i,
    input  logic retireValid_i,
    output logic retireRdy_o,
    output logic capture_o,
    input  logic netPending_i,
    output logic netLoad_o,
    output logic netReq_o,
    input  logic netAck_i,
    output logic traceReq_o,
    input  logic traceAck_i
);

    typedef enum logic [2:0] {
        IDLE,
        HOLD,
        NET_REQ,
        NET_WAIT_LOW,
        REC_REQ,
        REC_WAIT_LOW
    } ctrlState_t;

    ctrlState_t stateQ;
    ctrlState_t stateD;
    // Captured record still waiting to go out
    logic       recHeldQ;

    ////////////////////
    // Decoded outputs
    ////////////////////
    // Only accept when nothing is in flight
    assign retireRdy_o = (stateQ == IDLE);
    assign capture_o   = retireValid_i && retireRdy_o;
    // Nets win over the held record
    assign netLoad_o   = netPending_i && ((stateQ == IDLE) || (stateQ == HOLD));
    assign netReq_o    = (stateQ == NET_REQ);
    assign traceReq_o  = (stateQ == REC_REQ);

    ////////////////////
    // Next state
    ////////////////////
    always_comb begin
        stateD = stateQ;
        case (stateQ)
            IDLE: begin
                if (netLoad_o)
                    stateD = NET_REQ;
                else if (capture_o)
                    stateD = HOLD;
            end
            HOLD: begin
                // Record registers valid here
                if (netLoad_o)
                    stateD = NET_REQ;
                else
                    stateD = REC_REQ;
            end
            NET_REQ: begin
                if (netAck_i)
                    stateD = NET_WAIT_LOW;
            end
            NET_WAIT_LOW: begin
                // Back to the record if one was captured alongside
                if (!netAck_i)
                    stateD = recHeldQ ? HOLD : IDLE;
            end
            REC_REQ: begin
                if (traceAck_i)
                    stateD = REC_WAIT_LOW;
            end
            REC_WAIT_LOW: begin
                if (!traceAck_i)
                    stateD = IDLE;
            end
            default: stateD = IDLE;
        endcase
    end

    always_ff @(posedge rvvi) begin
        if (rst_i) begin
            stateQ   <= IDLE;
            recHeldQ <= 1'b0;
        end else begin
            stateQ <= stateD;
            if (capture_o)
                recHeldQ <= 1'b1;
            else if ((stateQ == REC_WAIT_LOW) && !traceAck_i)
                recHeldQ <= 1'b0;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Verilator build and run of the trace converter testbench
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbTop -f vlog.f -o tbTop
./obj_dir/tbTop | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* verification/rvviTraceConv_assert.sv */
// Handshake assertions for the trace converter
module rvviTraceConv_assert
    import rvviPkg::*;
(
    input logic      rvvi,
    input logic      rst_i,
    input logic      retireValid_i,
    input logic      retireRdy_o,
    input logic      traceReq_o,
    input traceOut_t trace_o,
    input logic      traceAck_i,
    input logic      netReq_o,
    input netEvent_t netEvent_o,
    input logic      netAck_i
);

    // Open from acceptance until the record ack falls
    logic recOpen;
    logic traceAckQ;

    always_ff @(posedge rvvi) begin
        if (rst_i) begin
            recOpen   <= 1'b0;
            traceAckQ <= 1'b0;
        end else begin
            traceAckQ <= traceAck_i;
            if (retireValid_i && retireRdy_o)
                recOpen <= 1'b1;
            else if (traceAckQ && !traceAck_i)
                recOpen <= 1'b0;
        end
    end

    // Both requests low out of reset
    assert property (@(posedge rvvi) rst_i |=> !traceReq_o && !netReq_o)
        else $error("request high after reset");

    // Request held until ack seen
    assert property (@(posedge rvvi) disable iff (rst_i)
                     traceReq_o && !traceAck_i |=> traceReq_o)
        else $error("traceReq_o dropped before ack");
    assert property (@(posedge rvvi) disable iff (rst_i)
                     netReq_o && !netAck_i |=> netReq_o)
        else $error("netReq_o dropped before ack");

    // Payload frozen under req
    assert property (@(posedge rvvi) disable iff (rst_i)
                     traceReq_o |=> !traceReq_o || $stable(trace_o))
        else $error("trace_o changed under traceReq_o");
    assert property (@(posedge rvvi) disable iff (rst_i)
                     netReq_o |=> !netReq_o || $stable(netEvent_o))
        else $error("netEvent_o changed under netReq_o");

    // Ready off from acceptance until the record ack falls
    assert property (@(posedge rvvi) disable iff (rst_i)
                     retireValid_i && retireRdy_o |=> !retireRdy_o)
        else $error("retireRdy_o high right after acceptance");
    assert property (@(posedge rvvi) disable iff (rst_i) recOpen |-> !retireRdy_o)
        else $error("retireRdy_o high before the record ack fell");

endmodule

bind rvviTraceConv rvviTraceConv_assert u_handshakeAssert (
    .rvvi          (rvvi),
    .rst_i         (rst_i),
    .retireValid_i (retireValid_i),
    .retireRdy_o   (retireRdy_o),
    .traceReq_o    (traceReq_o),
    .trace_o       (trace_o),
    .traceAck_i    (traceAck_i),
    .netReq_o      (netReq_o),
    .netEvent_o    (netEvent_o),
    .netAck_i      (netAck_i)
);

/* verification/tbChecker.sv */
// Trace converter reference model and checks
module tbChecker
    import rvfiPkg::*;
    import rvviPkg::*;
(
    input  logic                 rvvi,
    input  logic                 rst_i,
    input  logic                 retireValid_i,
    input  retireIn_t            retire_i,
    input  logic                 retireRdy_i,
    input  logic [NET_COUNT-1:0] nets_i,
    input  logic                 traceReq_i,
    input  traceOut_t            trace_i,
    input  logic                 netReq_i,
    input  netEvent_t            netEvent_i,
    input  logic                 quiet_i,
    output int                   errCount_o,
    output int                   recCount_o,
    output int                   netCount_o
);

    // Records accepted but not yet seen on the record channel
    traceOut_t            expQ [$];
    traceOut_t            expRec;
    xWord_t               lastCsr [CSR_COUNT];
    logic [NET_COUNT-1:0] lastRep;
    // Net lines one sample back, as the DUT saw them at load
    logic [NET_COUNT-1:0] prevNets;
    logic                 prevTraceReq;
    logic                 prevNetReq;
    logic                 prevQuiet;
    int                   errCount = 0;
    int                   recCount = 0;
    int                   netCount = 0;

    assign errCount_o = errCount;
    assign recCount_o = recCount;
    assign netCount_o = netCount;

    ////////////////////
    // Model
    ////////////////////
    function automatic traceOut_t expectRecord(retireIn_t r);
        traceOut_t e;
        e = '0;
        e.fields.order = r.order;
        e.fields.insn  = r.insn;
        e.fields.pc    = r.pc;
        e.fields.trap  = r.trap;
        e.fields.intr  = r.intr;
        e.fields.mode  = r.mode;
        // x0 stays clear
        for (int g = 1; g < 32; g++)
            e.fields.xWb[g] = (r.rdAddr[0] == regAddr_t'(g)) || (r.rdAddr[1] == regAddr_t'(g));
        e.fields.rdData[1] = r.rdWdata[1];
        e.fields.rdData[0] = (r.rdAddr[0] == r.rdAddr[1]) ? r.rdWdata[1] : r.rdWdata[0];
        for (int c = 0; c < CSR_COUNT; c++) begin
            // Flip the read bits that the mask selects and that wdata changes
            e.csr[c]   = r.csr[c].rdata ^ ((r.csr[c].rdata ^ r.csr[c].wdata) & r.csr[c].wmask);
            e.csrWb[c] = (e.csr[c] != lastCsr[c]);
        end
        return e;
    endfunction

    task automatic checkVal(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            errCount++;
        end
    endtask

    task automatic checkRecord(input traceOut_t e);
        checkVal("trace_o.order", e.fields.order, trace_i.fields.order);
        checkVal("trace_o.insn", 64'(e.fields.insn), 64'(trace_i.fields.insn));
        checkVal("trace_o.pc", 64'(e.fields.pc), 64'(trace_i.fields.pc));
        checkVal("trace_o.trap", 64'(e.fields.trap), 64'(trace_i.fields.trap));
        checkVal("trace_o.intr", 64'(e.fields.intr), 64'(trace_i.fields.intr));
        checkVal("trace_o.mode", 64'(e.fields.mode), 64'(trace_i.fields.mode));
        checkVal("trace_o.xWb", 64'(e.fields.xWb), 64'(trace_i.fields.xWb));
        checkVal("trace_o.rdData[0]", 64'(e.fields.rdData[0]), 64'(trace_i.fields.rdData[0]));
        checkVal("trace_o.rdData[1]", 64'(e.fields.rdData[1]), 64'(trace_i.fields.rdData[1]));
        for (int c = 0; c < CSR_COUNT; c++)
            checkVal($sformatf("trace_o.csr[%03h]", CSR_ADDR[c]), 64'(e.csr[c]),
                     64'(trace_i.csr[c]));
        checkVal("trace_o.csrWb", 64'(e.csrWb), 64'(trace_i.csrWb));
    endtask

    task automatic checkNetEvent();
        int lowest;
        lowest = -1;
        for (int n = NET_COUNT - 1; n >= 0; n--) begin
            if (prevNets[n] != lastRep[n])
                lowest = n;
        end
        if (lowest < 0) begin
            $display("Net event for index %0d sent while no net was pending", netEvent_i.idx);
            errCount++;
        end else begin
            checkVal("netEvent_o.idx", 64'(lowest), 64'(netEvent_i.idx));
            checkVal("netEvent_o.value", 64'(prevNets[lowest]), 64'(netEvent_i.value));
        end
        if (int'(netEvent_i.idx) >= NET_COUNT) begin
            $display("Net event index %0d is out of range", netEvent_i.idx);
            errCount++;
        end else if (netEvent_i.value == lastRep[netEvent_i.idx]) begin
            $display("Net %0d reported again with unchanged value", netEvent_i.idx);
            errCount++;
        end else begin
            lastRep[netEvent_i.idx] = netEvent_i.value;
        end
        netCount++;
    endtask

    ////////////////////
    // Observation at the falling edge
    ////////////////////
    always @(negedge rvvi) begin
        if (rst_i) begin
            expQ.delete();
            for (int c = 0; c < CSR_COUNT; c++)
                lastCsr[c] = '0;
            lastRep      = '0;
            prevTraceReq = 1'b0;
            prevNetReq   = 1'b0;
            prevQuiet    = 1'b0;
        end else begin
            if (retireValid_i && retireRdy_i) begin
                expRec = expectRecord(retire_i);
                expQ.push_back(expRec);
                for (int c = 0; c < CSR_COUNT; c++)
                    lastCsr[c] = expRec.csr[c];
            end
            if (traceReq_i && !prevTraceReq) begin
                if (expQ.size() == 0) begin
                    $display("Record sent with no accepted retirement behind it");
                    errCount++;
                end else begin
                    checkRecord(expQ.pop_front());
                    recCount++;
                end
            end
            if (netReq_i && !prevNetReq)
                checkNetEvent();
            // Everything sent by the time the lines go quiet
            if (quiet_i && !prevQuiet && expQ.size() != 0) begin
                $display("%0d accepted retirements never left the DUT", expQ.size());
                errCount++;
            end
            if (quiet_i && netReq_i) begin
                $display("netReq_o high at %0t while the nets are quiet", $time);
                errCount++;
            end
            if (quiet_i && nets_i !== lastRep) begin
                $display("Net lines %h differ from last reported %h", nets_i, lastRep);
                errCount++;
            end
            prevTraceReq = traceReq_i;
            prevNetReq   = netReq_i;
            prevQuiet    = quiet_i;
        end
        prevNets = nets_i;
    end

endmodule

/* verification/tbTop.sv */
// Trace converter testbench top
module tbTop
    import rvfiPkg::*;
    import rvviPkg::*;
();

    localparam int WAIT_LIMIT = 500;

    logic                 rvvi     = 1'b0;
    logic                 rst;
    logic                 retireValid;
    retireIn_t            retireRec;
    logic                 retireRdy;
    logic [NET_COUNT-1:0] nets     = '0;
    logic                 traceReq;
    traceOut_t            traceRec;
    logic                 traceAck = 1'b0;
    logic                 netReq;
    netEvent_t            netEvent;
    logic                 netAck   = 1'b0;

    // Stimulus state
    logic                    netsOn   = 1'b0;
    int                      netRate  = 15;
    logic                    quiet    = 1'b0;
    logic                    timedOut = 1'b0;
    order_t                  orderCnt;
    csrRec_t [CSR_COUNT-1:0] prevCsr;
    int                      traceDly = 0;
    int                      netDly   = 0;
    int                      netFlip;
    int                      errBase  = 0;
    int                      errCount;
    int                      recCount;
    int                      netCount;

    always #10 rvvi = ~rvvi;

    rvviTraceConv u_rvviTraceConv (
        .rvvi          (rvvi),
        .rst_i         (rst),
        .retireValid_i (retireValid),
        .retire_i      (retireRec),
        .retireRdy_o   (retireRdy),
        .nets_i        (nets),
        .traceReq_o    (traceReq),
        .trace_o       (traceRec),
        .traceAck_i    (traceAck),
        .netReq_o      (netReq),
        .netEvent_o    (netEvent),
        .netAck_i      (netAck)
    );

    tbChecker u_checker (
        .rvvi          (rvvi),
        .rst_i         (rst),
        .retireValid_i (retireValid),
        .retire_i      (retireRec),
        .retireRdy_i   (retireRdy),
        .nets_i        (nets),
        .traceReq_i    (traceReq),
        .trace_i       (traceRec),
        .netReq_i      (netReq),
        .netEvent_i    (netEvent),
        .quiet_i       (quiet),
        .errCount_o    (errCount),
        .recCount_o    (recCount),
        .netCount_o    (netCount)
    );

    ////////////////////
    // Responders and net toggles
    ////////////////////
    // Mostly short, now and then a long stall
    function automatic int ackDelay();
        if ($urandom_range(0, 7) == 0)
            return $urandom_range(6, 14);
        return $urandom_range(0, 2);
    endfunction

    // Ack follows req after a random number of cycles
    always @(posedge rvvi) begin
        #1;
        if (rst) begin
            traceAck = 1'b0;
            traceDly = 0;
        end else if (traceReq != traceAck) begin
            if (traceDly == 0) begin
                traceAck = traceReq;
                traceDly = ackDelay();
            end else begin
                traceDly--;
            end
        end
    end

    always @(posedge rvvi) begin
        #1;
        if (rst) begin
            netAck = 1'b0;
            netDly = 0;
        end else if (netReq != netAck) begin
            if (netDly == 0) begin
                netAck = netReq;
                netDly = ackDelay();
            end else begin
                netDly--;
            end
        end
    end

    // One line flips now and then
    always @(posedge rvvi) begin
        #1;
        if (netsOn && !rst && $urandom_range(0, netRate) == 0) begin
            netFlip       = $urandom_range(0, NET_COUNT - 1);
            nets[netFlip] = ~nets[netFlip];
        end
    end

    ////////////////////
    // Stimulus tasks
    ////////////////////
    task automatic makeRecord(input bit rdCorner, output retireIn_t rec);
        int pick;
        rec.order = orderCnt;
        orderCnt++;
        rec.insn  = $urandom;
        rec.pc    = $urandom & 32'hffff_fffc;
        rec.trap  = ($urandom_range(0, 15) == 0);
        rec.intr  = ($urandom_range(0, 31) == 0);
        rec.mode  = mode_t'($urandom_range(0, 3));
        for (int s = 0; s < RD_SLOTS; s++) begin
            rec.rdAddr[s]  = regAddr_t'($urandom_range(0, 31));
            rec.rdWdata[s] = $urandom;
        end
        // Same register in both slots, or x0
        if (rdCorner) begin
            pick = $urandom_range(0, 3);
            if (pick == 0)
                rec.rdAddr[0] = rec.rdAddr[1];
            else if (pick == 1)
                rec.rdAddr[0] = '0;
            else if (pick == 2)
                rec.rdAddr[1] = '0;
            else
                rec.rdAddr = '0;
        end
        // Half the CSRs repeat, so most records change only a few
        for (int c = 0; c < CSR_COUNT; c++) begin
            if ($urandom_range(0, 1) == 0) begin
                rec.csr[c] = prevCsr[c];
            end else begin
                rec.csr[c].rdata = $urandom;
                rec.csr[c].wdata = $urandom;
                pick = $urandom_range(0, 2);
                rec.csr[c].wmask = (pick == 0) ? '0 : (pick == 1) ? '1 : $urandom;
            end
        end
        prevCsr = rec.csr;
    endtask

    task automatic sendRecord(input bit rdCorner);
        retireIn_t rec;
        int        waitCnt;
        int        gap;
        makeRecord(rdCorner, rec);
        retireRec   = rec;
        retireValid = 1'b1;
        waitCnt     = 0;
        // Ready at the falling edge means acceptance at the next rising edge
        @(negedge rvvi);
        while (!retireRdy && !timedOut) begin
            waitCnt++;
            if (waitCnt > WAIT_LIMIT) begin
                $display("Timeout: retirement %0d not accepted in %0d cycles",
                         rec.order, WAIT_LIMIT);
                timedOut = 1'b1;
            end else begin
                @(negedge rvvi);
            end
        end
        @(posedge rvvi);
        #1;
        retireValid = 1'b0;
        gap = $urandom_range(0, 3);
        repeat (gap) begin
            @(posedge rvvi);
            #1;
        end
    endtask

    // Idle means ready high and both acks low
    task automatic waitIdle(input int need);
        int run;
        int waitCnt;
        run     = 0;
        waitCnt = 0;
        while (run < need && !timedOut) begin
            @(negedge rvvi);
            if (retireRdy && !traceAck && !netAck)
                run++;
            else
                run = 0;
            waitCnt++;
            if (waitCnt > WAIT_LIMIT) begin
                $display("Timeout: DUT not idle within %0d cycles", WAIT_LIMIT);
                timedOut = 1'b1;
            end
        end
        @(posedge rvvi);
        #1;
    endtask

    task automatic finishTest(input string name);
        int errs;
        errs    = errCount - errBase;
        errBase = errCount;
        if (errs == 0 && !timedOut)
            $display("Test %s: passed, %0d records and %0d net events so far",
                     name, recCount, netCount);
        else
            $display("Test %s: failed with %0d errors", name, errs);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        void'($urandom(32'hc38f));
        rst         = 1'b1;
        retireValid = 1'b0;
        retireRec   = '0;
        orderCnt    = '0;
        prevCsr     = '0;
        repeat (5) @(posedge rvvi);
        #1;
        rst = 1'b0;

        // Plain random records, sparse nets
        netsOn = 1'b1;
        for (int i = 0; i < 80 && !timedOut; i++)
            sendRecord(1'b0);
        waitIdle(1);
        finishTest("random records");

        for (int i = 0; i < 60 && !timedOut; i++)
            sendRecord(1'b1);
        waitIdle(1);
        finishTest("rd corners");

        // No retirements, denser nets
        netRate = 3;
        repeat (300) begin
            @(posedge rvvi);
            #1;
        end
        waitIdle(1);
        finishTest("nets while idle");

        // Lines settle, nothing may be sent
        netsOn = 1'b0;
        waitIdle(8);
        quiet = 1'b1;
        repeat (30) begin
            @(posedge rvvi);
            #1;
        end
        quiet = 1'b0;
        finishTest("quiet nets");

        $display("Totals: %0d records, %0d net events, %0d errors",
                 recCount, netCount, errCount);
        if (timedOut || errCount != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/rvfiPkg.sv
rtl/rvviPkg.sv
rtl/traceCtrl.sv
rtl/retireCapture.sv
rtl/csrMerge.sv
rtl/netMonitor.sv
rtl/rvviTraceConv.sv
verification/rvviTraceConv_assert.sv
verification/tbChecker.sv
verification/tbTop.sv
